/* sim.f */
hdl/ex_isa_pkg.sv
hdl/ex_pipe_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_issue_ctrl.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
tb/ex_stage_checker.sv
tb/ex_stage_tb.sv

/* tb/ex_stage_tb.sv */
/*
 * Directed testbench for the execute stage.
 * Runs reset, ALU, multiplier, forwarding and back-pressure tests
 * against reference functions and prints one closing summary.
 */

`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;

  import ex_isa_pkg::*;
  import ex_pipe_pkg::*;

  // Cycles allowed for any wait loop
  localparam int WAIT_LIMIT = 20;

  logic              clk;
  logic              rst_n;
  alu_req_t          alu_req;
  logic              alu_en;
  mult_req_t         mult_req;
  logic              mult_en;
  logic              csr_access;
  logic [DATA_W-1:0] csr_rdata;
  logic              lsu_en;
  logic [DATA_W-1:0] lsu_rdata;
  logic              lsu_ready_ex;
  rf_dest_t          alu_dest;
  rf_dest_t          lsu_dest;
  logic              branch_in_ex;
  logic              wb_ready;
  rf_write_t         fw_port;
  rf_write_t         wb_port;
  logic              branch_decision;
  logic [DATA_W-1:0] jump_target;
  logic              ex_ready;
  logic              ex_valid;
  int                error_cnt = 0;

  ex_stage u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req),
    .alu_en_i          (alu_en),
    .mult_req_i        (mult_req),
    .mult_en_i         (mult_en),
    .csr_access_i      (csr_access),
    .csr_rdata_i       (csr_rdata),
    .lsu_en_i          (lsu_en),
    .lsu_rdata_i       (lsu_rdata),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .alu_dest_i        (alu_dest),
    .lsu_dest_i        (lsu_dest),
    .branch_in_ex_i    (branch_in_ex),
    .wb_ready_i        (wb_ready),
    .fw_port_o         (fw_port),
    .wb_port_o         (wb_port),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model and checking
  ////////////////////////////////////////////////////////////

  // Returns {flag, result}; compares put the flag in bit 0
  function automatic logic [32:0] alu_ref(input alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [31:0] res;
    logic        flag;
    res  = '0;
    flag = 1'b0;
    case (op)
      ALU_ADD:           res = a + b;
      ALU_SUB:           res = a - b;
      ALU_AND:           res = a & b;
      ALU_OR:            res = a | b;
      ALU_XOR:           res = a ^ b;
      ALU_SLL:           res = a << b[4:0];
      ALU_SRL:           res = a >> b[4:0];
      ALU_SRA:           res = $unsigned($signed(a) >>> b[4:0]);
      ALU_SLT, ALU_LT:   flag = $signed(a) < $signed(b);
      ALU_SLTU, ALU_LTU: flag = a < b;
      ALU_EQ:            flag = (a == b);
      ALU_NE:            flag = (a != b);
      ALU_GE:            flag = $signed(a) >= $signed(b);
      ALU_GEU:           flag = a >= b;
      default:           res = '0;
    endcase
    // All opcodes from SLT upward are comparisons
    if (op >= ALU_SLT) begin
      res = {31'b0, flag};
    end
    return {flag, res};
  endfunction

  // Full 64-bit product of the extended operands
  function automatic logic [31:0] mult_ref(input mult_op_e op, input logic [31:0] a,
                                           input logic [31:0] b);
    logic [63:0] a_ext;
    logic [63:0] b_ext;
    logic [63:0] prod;
    a_ext = {{32{a[31] & ((op == MUL_H) || (op == MUL_HSU))}}, a};
    b_ext = {{32{b[31] & (op == MUL_H)}}, b};
    prod  = a_ext * b_ext;
    return (op == MUL_LO) ? prod[31:0] : prod[63:32];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      error_cnt++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Counts cycles until stage ready rises; valid must stay low meanwhile
  task automatic wait_ready(output int cycles);
    cycles = 0;
    while (ex_ready !== 1'b1) begin
      if (cycles >= WAIT_LIMIT) begin
        error_cnt++;
        $display("Timeout: stage ready stayed low for %0d cycles", cycles);
        return;
      end
      check_value("ex_valid_o", ex_valid, 1'b0);
      cycles++;
      @(negedge clk);
      #1;
    end
  endtask

  task automatic idle_inputs();
    alu_en       = 1'b0;
    mult_en      = 1'b0;
    csr_access   = 1'b0;
    lsu_en       = 1'b0;
    branch_in_ex = 1'b0;
    lsu_ready_ex = 1'b1;
    wb_ready     = 1'b1;
    alu_dest     = '0;
    lsu_dest     = '0;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic reset_state_test();
    #1;
    check_value("wb_port_o.we", wb_port.we, 1'b0);
    check_value("ex_ready_o", ex_ready, 1'b1);
    check_value("ex_valid_o", ex_valid, 1'b0);
    @(negedge clk);
    #1;
    check_value("wb_port_o.we", wb_port.we, 1'b0);
  endtask

  task automatic alu_ops_test();
    logic [31:0] edge_a [4];
    logic [31:0] edge_b [4];
    logic [31:0] a;
    logic [31:0] b;
    logic [32:0] exp;
    edge_a = '{32'h0000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff};
    edge_b = '{32'h0000_0000, 32'h7fff_ffff, 32'h0000_001f, 32'h8000_0000};
    for (int op = 0; op < 16; op++) begin
      for (int i = 0; i < 8; i++) begin
        // Edge pairs first, then random ones with one equal pair
        a = (i < 4) ? edge_a[i] : $urandom;
        b = (i < 4) ? edge_b[i] : ((i == 5) ? a : $urandom);
        @(negedge clk);
        alu_req.op    = alu_op_e'(op[3:0]);
        alu_req.a     = a;
        alu_req.b     = b;
        alu_req.c     = $urandom;
        alu_en        = 1'b1;
        alu_dest.we   = $urandom;
        alu_dest.addr = RF_ADDR_W'($urandom);
        #1;
        exp = alu_ref(alu_op_e'(op[3:0]), a, b);
        check_value("fw_port_o.data", fw_port.data, exp[31:0]);
        check_value("fw_port_o.we", fw_port.we, alu_dest.we);
        check_value("fw_port_o.addr", fw_port.addr, alu_dest.addr);
        check_value("branch_decision_o", branch_decision, exp[32]);
        check_value("jump_target_o", jump_target, alu_req.c);
      end
    end
    @(negedge clk);
    idle_inputs();
  endtask

  task automatic mult_test();
    logic [31:0] a;
    logic [31:0] b;
    int          busy;
    // Low word settles in the enable cycle
    @(negedge clk);
    mult_req.op = MUL_LO;
    mult_req.a  = $urandom;
    mult_req.b  = $urandom;
    mult_en     = 1'b1;
    #1;
    check_value("fw_port_o.data", fw_port.data, mult_ref(MUL_LO, mult_req.a, mult_req.b));
    check_value("ex_ready_o", ex_ready, 1'b1);
    for (int k = 1; k < 4; k++) begin
      for (int i = 0; i < 4; i++) begin
        a = (i == 0) ? 32'h8000_0000 : ((i == 1) ? 32'hffff_ffff : $urandom);
        b = (i < 2) ? 32'hffff_ffff : $urandom;
        @(negedge clk);
        mult_req.op = mult_op_e'(k[1:0]);
        mult_req.a  = a;
        mult_req.b  = b;
        #1;
        // Two busy cycles with 16-bit chunks
        wait_ready(busy);
        check_value("mult busy cycles", busy, 2);
        check_value("fw_port_o.data", fw_port.data, mult_ref(mult_op_e'(k[1:0]), a, b));
        check_value("ex_valid_o", ex_valid, 1'b1);
      end
    end
    @(negedge clk);
    idle_inputs();
  endtask

  task automatic forward_lsu_test();
    logic [RF_ADDR_W-1:0] addr;
    // CSR beats ALU, multiplier beats ALU
    @(negedge clk);
    alu_req.op = ALU_ADD;
    alu_req.a  = $urandom;
    alu_req.b  = $urandom;
    alu_en     = 1'b1;
    csr_access = 1'b1;
    csr_rdata  = $urandom;
    #1;
    check_value("fw_port_o.data", fw_port.data, csr_rdata);
    @(negedge clk);
    csr_access  = 1'b0;
    mult_en     = 1'b1;
    mult_req.op = MUL_LO;
    mult_req.a  = $urandom;
    mult_req.b  = $urandom;
    #1;
    check_value("fw_port_o.data", fw_port.data, mult_ref(MUL_LO, mult_req.a, mult_req.b));
    // Load with a destination goes into the EX/WB register
    @(negedge clk);
    idle_inputs();
    addr          = RF_ADDR_W'($urandom);
    lsu_en        = 1'b1;
    lsu_dest.we   = 1'b1;
    lsu_dest.addr = addr;
    #1;
    check_value("ex_valid_o", ex_valid, 1'b1);
    @(negedge clk);
    idle_inputs();
    lsu_rdata = $urandom;
    #1;
    check_value("wb_port_o.we", wb_port.we, 1'b1);
    check_value("wb_port_o.addr", wb_port.addr, addr);
    check_value("wb_port_o.data", wb_port.data, lsu_rdata);
    // Idle cycle flushes it
    @(negedge clk);
    #1;
    check_value("wb_port_o.we", wb_port.we, 1'b0);
  endtask

  task automatic backpressure_test();
    logic [RF_ADDR_W-1:0] addr;
    @(negedge clk);
    addr          = RF_ADDR_W'($urandom);
    lsu_en        = 1'b1;
    lsu_dest.we   = 1'b1;
    lsu_dest.addr = addr;
    // Stall write-back with a new load waiting
    @(negedge clk);
    wb_ready      = 1'b0;
    lsu_dest.addr = ~addr;
    #1;
    check_value("ex_ready_o", ex_ready, 1'b0);
    check_value("ex_valid_o", ex_valid, 1'b0);
    check_value("wb_port_o.we", wb_port.we, 1'b1);
    check_value("wb_port_o.addr", wb_port.addr, addr);
    @(negedge clk);
    #1;
    check_value("wb_port_o.we", wb_port.we, 1'b1);
    check_value("wb_port_o.addr", wb_port.addr, addr);
    // Branch overrides the load/store stall
    @(negedge clk);
    idle_inputs();
    lsu_ready_ex = 1'b0;
    branch_in_ex = 1'b1;
    #1;
    check_value("ex_ready_o", ex_ready, 1'b1);
    check_value("ex_valid_o", ex_valid, 1'b0);
    @(negedge clk);
    idle_inputs();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(61249));
    clk       = 1'b0;
    rst_n     = 1'b0;
    alu_req   = '0;
    mult_req  = '0;
    csr_rdata = '0;
    lsu_rdata = '0;
    idle_inputs();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_state_test();
    alu_ops_test();
    mult_test();
    forward_lsu_test();
    backpressure_test();

    @(negedge clk);
    $display("Check errors: %0d, assertion failures: %0d",
             error_cnt, u_dut.u_checker.fail_cnt);
    if ((error_cnt == 0) && (u_dut.u_checker.fail_cnt == 0)) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/ex_stage_checker.sv */
/*
 * Concurrent assertions on the execute stage stall control.
 * Bound into every ex_stage instance; the testbench reads fail_cnt.
 */

`timescale 1ns/1ps
`default_nettype none

module ex_stage_checker (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_i,
  input  logic ready_i,
  input  logic wb_ready_i,
  input  logic branch_in_ex_i,
  input  logic wb_we_i
);

  // Number of assertion failures seen so far
  int unsigned fail_cnt = 0;

  // Valid never goes out while write-back is stalled
  valid_needs_wb_ready: assert property (
    @(posedge clk) disable iff (!rst_n) valid_i |-> wb_ready_i
  ) else begin
    fail_cnt++;
    $error("Stage valid high while write-back is not ready");
  end

  // Branch in EX always lets decode proceed
  branch_gives_ready: assert property (
    @(posedge clk) disable iff (!rst_n) branch_in_ex_i |-> ready_i
  ) else begin
    fail_cnt++;
    $error("Branch in EX without stage ready");
  end

  // EX/WB register stays empty through the first cycle out of reset
  wb_we_low_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |=> !wb_we_i
  ) else begin
    fail_cnt++;
    $error("Write-back enable set right after reset release");
  end

endmodule

bind ex_stage ex_stage_checker u_checker (
  .clk            (clk),
  .rst_n          (rst_n),
  .valid_i        (ex_valid_o),
  .ready_i        (ex_ready_o),
  .wb_ready_i     (wb_ready_i),
  .branch_in_ex_i (branch_in_ex_i),
  .wb_we_i        (wb_port_o.we)
);

`default_nettype wire

/* hdl/ex_stage.sv */
/*
 * Execute stage top level.
 * Connects stall control, ALU, multiplier and the write ports;
 * the branch decision and jump target leave from here.
 */

`timescale 1ns/1ps
`default_nettype none

module ex_stage #(
  parameter int MULT_CHUNK_W = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // Requests from decode
  input  ex_pipe_pkg::alu_req_t          alu_req_i,
  input  logic                           alu_en_i,
  input  ex_pipe_pkg::mult_req_t         mult_req_i,
  input  logic                           mult_en_i,
  // CSR read
  input  logic                           csr_access_i,
  input  logic [ex_isa_pkg::DATA_W-1:0]  csr_rdata_i,
  // Load/store unit
  input  logic                           lsu_en_i,
  input  logic [ex_isa_pkg::DATA_W-1:0]  lsu_rdata_i,
  input  logic                           lsu_ready_ex_i,
  // Destinations
  input  ex_pipe_pkg::rf_dest_t          alu_dest_i,
  input  ex_pipe_pkg::rf_dest_t          lsu_dest_i,
  input  logic                           branch_in_ex_i,
  input  logic                           wb_ready_i,
  // Write ports
  output ex_pipe_pkg::rf_write_t         fw_port_o,
  output ex_pipe_pkg::rf_write_t         wb_port_o,
  // To fetch
  output logic                           branch_decision_o,
  output logic [ex_isa_pkg::DATA_W-1:0]  jump_target_o,
  // Stall control
  output logic                           ex_ready_o,
  output logic                           ex_valid_o
);

  import ex_isa_pkg::*;

  logic [DATA_W-1:0] alu_result;
  logic [DATA_W-1:0] mult_result;
  logic              alu_cmp;
  logic              mult_ready;
  logic              ex_ready;
  logic              ex_valid;

  ////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////

  ex_issue_ctrl u_issue (
    .alu_en_i       (alu_en_i),
    .mult_en_i      (mult_en_i),
    .csr_access_i   (csr_access_i),
    .lsu_en_i       (lsu_en_i),
    .mult_ready_i   (mult_ready),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .wb_ready_i     (wb_ready_i),
    .branch_in_ex_i (branch_in_ex_i),
    .ex_ready_o     (ex_ready),
    .ex_valid_o     (ex_valid)
  );

  ////////////////////////////////////////////////////////////
  // Processing
  ////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .req_i        (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  // Multiplier leaves DONE once the whole stage moves
  ex_mult #(
    .MULT_CHUNK_W (MULT_CHUNK_W)
  ) u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .en_i       (mult_en_i),
    .req_i      (mult_req_i),
    .ex_ready_i (ex_ready),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  ////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////

  ex_writeback u_wb (
    .clk           (clk),
    .rst_n         (rst_n),
    .alu_en_i      (alu_en_i),
    .mult_en_i     (mult_en_i),
    .csr_access_i  (csr_access_i),
    .ex_valid_i    (ex_valid),
    .wb_ready_i    (wb_ready_i),
    .alu_result_i  (alu_result),
    .mult_result_i (mult_result),
    .csr_rdata_i   (csr_rdata_i),
    .lsu_rdata_i   (lsu_rdata_i),
    .alu_dest_i    (alu_dest_i),
    .lsu_dest_i    (lsu_dest_i),
    .fw_port_o     (fw_port_o),
    .wb_port_o     (wb_port_o)
  );

  // Branch resolved by the ALU compare, target from operand c
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.c;

  assign ex_ready_o = ex_ready;
  assign ex_valid_o = ex_valid;

endmodule

`default_nettype wire

/* hdl/ex_writeback.sv */
/*
 * Output side of the execute stage.
 * Forwarding write port with its result mux, and the EX/WB
 * register that drives the load/store write-back port.
 */

`timescale 1ns/1ps
`default_nettype none

module ex_writeback (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           alu_en_i,
  input  logic                           mult_en_i,
  input  logic                           csr_access_i,
  input  logic                           ex_valid_i,
  input  logic                           wb_ready_i,
  input  logic [ex_isa_pkg::DATA_W-1:0]  alu_result_i,
  input  logic [ex_isa_pkg::DATA_W-1:0]  mult_result_i,
  input  logic [ex_isa_pkg::DATA_W-1:0]  csr_rdata_i,
  input  logic [ex_isa_pkg::DATA_W-1:0]  lsu_rdata_i,
  input  ex_pipe_pkg::rf_dest_t          alu_dest_i,
  input  ex_pipe_pkg::rf_dest_t          lsu_dest_i,
  output ex_pipe_pkg::rf_write_t         fw_port_o,
  output ex_pipe_pkg::rf_write_t         wb_port_o
);

  import ex_pipe_pkg::*;

  // Load/store destination held for the WB stage
  rf_dest_t lsu_dest_q;

  ////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Destination passes straight through from decode
    fw_port_o.we   = alu_dest_i.we;
    fw_port_o.addr = alu_dest_i.addr;
    fw_port_o.data = '0;
    // Later source wins when enables overlap
    if (alu_en_i) begin
      fw_port_o.data = alu_result_i;
    end
    if (mult_en_i) begin
      fw_port_o.data = mult_result_i;
    end
    if (csr_access_i) begin
      fw_port_o.data = csr_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_dest_q <= '0;
    end else if (ex_valid_i) begin
      // Valid already implies write-back is ready
      lsu_dest_q.we <= lsu_dest_i.we;
      if (lsu_dest_i.we) begin
        lsu_dest_q.addr <= lsu_dest_i.addr;
      end
    end else if (wb_ready_i) begin
      // Nothing new arrives, flush the old write
      lsu_dest_q.we <= 1'b0;
    end
  end

  // Load data arrives in the WB cycle itself
  assign wb_port_o.we   = lsu_dest_q.we;
  assign wb_port_o.addr = lsu_dest_q.addr;
  assign wb_port_o.data = lsu_rdata_i;

endmodule

`default_nettype wire

/* hdl/ex_issue_ctrl.sv */
/*
 * Stall control of the execute stage.
 * Combines unit readiness and instruction enables into stage
 * ready towards decode and stage valid towards write-back.
 */

`timescale 1ns/1ps
`default_nettype none

module ex_issue_ctrl (
  input  logic alu_en_i,
  input  logic mult_en_i,
  input  logic csr_access_i,
  input  logic lsu_en_i,
  input  logic mult_ready_i,
  input  logic lsu_ready_ex_i,
  input  logic wb_ready_i,
  input  logic branch_in_ex_i,
  output logic ex_ready_o,
  output logic ex_valid_o
);

  logic units_ready;
  logic any_en;

  // All units done and write-back can take a result
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Some instruction occupies the stage
  assign any_en = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // A branch finishes in EX without going to write-back,
  // so it always lets the next instruction in
  assign ex_ready_o = units_ready | branch_in_ex_i;

  // Valid flows downstream and does not look at ready
  assign ex_valid_o = any_en & units_ready;

endmodule

`default_nettype wire

/* hdl/ex_mult.sv */
/*
 * Integer multiplier of the execute stage.
 * Low word in one cycle; high words accumulate one chunk of b per
 * step into a 64-bit sum and wait in DONE until the stage moves on.
 */

`timescale 1ns/1ps
`default_nettype none

module ex_mult #(
  parameter int MULT_CHUNK_W = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           en_i,
  input  ex_pipe_pkg::mult_req_t         req_i,
  input  logic                           ex_ready_i,
  output logic [ex_isa_pkg::DATA_W-1:0]  result_o,
  output logic                           ready_o
);

  import ex_isa_pkg::*;

  // Steps per high-word multiply
  localparam int STEPS = DATA_W / MULT_CHUNK_W;
  localparam int CNT_W = (STEPS > 1) ? $clog2(STEPS) : 1;
  localparam int ACC_W = 2 * DATA_W;

  typedef enum logic [1:0] {
    IDLE,
    ACCUM,
    DONE
  } mult_state_e;

  mult_state_e       state_q;
  logic [CNT_W-1:0]  step_cnt_q;
  logic [ACC_W-1:0]  acc_q;

  logic              is_high;
  logic              start;
  logic              signed_a;
  logic              signed_b;
  logic [CNT_W-1:0]  step_idx;
  logic              last_step;
  logic [DATA_W-1:0] b_shifted;
  logic [MULT_CHUNK_W-1:0] chunk;
  logic              chunk_sign;
  logic [ACC_W-1:0]  a_ext;
  logic [ACC_W-1:0]  chunk_ext;
  logic [ACC_W-1:0]  pp;
  logic [ACC_W-1:0]  acc_base;
  logic [ACC_W-1:0]  acc_next;
  logic [DATA_W-1:0] lo_result;

  ////////////////////////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////////////////////////

  assign is_high  = (req_i.op != MUL_LO);
  assign start    = (state_q == IDLE) & en_i & is_high;
  assign signed_a = (req_i.op == MUL_H) | (req_i.op == MUL_HSU);
  assign signed_b = (req_i.op == MUL_H);

  // First step comes straight from IDLE
  assign step_idx  = (state_q == IDLE) ? '0 : step_cnt_q;
  assign last_step = (step_idx == CNT_W'(STEPS - 1));

  // Current chunk of b, top chunk carries the sign of b
  assign b_shifted  = req_i.b >> (step_idx * MULT_CHUNK_W);
  assign chunk      = b_shifted[MULT_CHUNK_W-1:0];
  assign chunk_sign = last_step & signed_b & chunk[MULT_CHUNK_W-1];
  assign chunk_ext  = {{(ACC_W-MULT_CHUNK_W){chunk_sign}}, chunk};
  assign a_ext      = {{DATA_W{signed_a & req_i.a[DATA_W-1]}}, req_i.a};

  // Partial product aligned to its chunk position, modulo 2^64
  assign pp       = (a_ext * chunk_ext) << (step_idx * MULT_CHUNK_W);
  assign acc_base = (state_q == IDLE) ? '0 : acc_q;
  assign acc_next = acc_base + pp;

  // Single-cycle low word
  assign lo_result = req_i.a * req_i.b;

  ////////////////////////////////////////////////////////////
  // High-word FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      step_cnt_q <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (start) begin
            step_cnt_q <= CNT_W'(1);
            state_q    <= last_step ? DONE : ACCUM;
          end
        end
        ACCUM: begin
          step_cnt_q <= step_cnt_q + CNT_W'(1);
          if (last_step) begin
            state_q <= DONE;
          end
        end
        // Hold the high word until the stage accepts it
        DONE: begin
          if (ex_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Accumulator is written on every busy step
  always_ff @(posedge clk) begin
    if (start || (state_q == ACCUM)) begin
      acc_q <= acc_next;
    end
  end

  // Busy from the first enabled cycle until DONE
  assign ready_o  = (state_q == DONE) | ((state_q == IDLE) & ~start);
  assign result_o = (state_q == DONE) ? acc_q[ACC_W-1:DATA_W] : lo_result;

endmodule

`default_nettype wire

/* hdl/ex_alu.sv */
/*
 * Combinational integer ALU of the execute stage.
 * Produces the result word and the comparison flag that drives
 * the branch decision. Always ready, no internal state.
 */

`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  ex_pipe_pkg::alu_req_t            req_i,
  output logic [ex_isa_pkg::DATA_W-1:0]    result_o,
  output logic                             cmp_result_o
);

  import ex_isa_pkg::*;

  logic              sub_sel;
  logic [DATA_W-1:0] adder_b;
  logic [DATA_W-1:0] adder_out;
  logic [4:0]        shamt;
  logic              eq;
  logic              lt_s;
  logic              lt_u;

  ////////////////////////////////////////////////////////////
  // Shared datapath pieces
  ////////////////////////////////////////////////////////////

  // One adder for add and subtract
  assign sub_sel   = (req_i.op == ALU_SUB);
  assign adder_b   = sub_sel ? ~req_i.b : req_i.b;
  assign adder_out = req_i.a + adder_b + {{(DATA_W-1){1'b0}}, sub_sel};

  // Shift amount from the low bits of b
  assign shamt = req_i.b[4:0];

  // Comparator outputs
  assign eq   = (req_i.a == req_i.b);
  assign lt_s = ($signed(req_i.a) < $signed(req_i.b));
  assign lt_u = (req_i.a < req_i.b);

  ////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    result_o     = '0;
    cmp_result_o = 1'b0;
    unique case (req_i.op)
      ALU_ADD,
      ALU_SUB: result_o = adder_out;
      ALU_AND: result_o = req_i.a & req_i.b;
      ALU_OR:  result_o = req_i.a | req_i.b;
      ALU_XOR: result_o = req_i.a ^ req_i.b;
      ALU_SLL: result_o = req_i.a << shamt;
      ALU_SRL: result_o = req_i.a >> shamt;
      // Arithmetic shift keeps the sign of a
      ALU_SRA: result_o = $unsigned($signed(req_i.a) >>> shamt);
      // Set-less-than also raises the flag
      ALU_SLT:  cmp_result_o = lt_s;
      ALU_SLTU: cmp_result_o = lt_u;
      // Branch comparisons
      ALU_EQ:  cmp_result_o = eq;
      ALU_NE:  cmp_result_o = ~eq;
      ALU_LT:  cmp_result_o = lt_s;
      ALU_GE:  cmp_result_o = ~lt_s;
      ALU_LTU: cmp_result_o = lt_u;
      ALU_GEU: cmp_result_o = ~lt_u;
      default: result_o = '0;
    endcase

    // Compare results land in bit 0
    if (req_i.op inside {ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
                         ALU_LT, ALU_GE, ALU_LTU, ALU_GEU}) begin
      result_o = {{(DATA_W-1){1'b0}}, cmp_result_o};
    end
  end

endmodule

`default_nettype wire

/* hdl/ex_pipe_pkg.sv */
/*
 * Pipeline-level structs for the execute stage.
 * Requests from decode, destination registers and register-file
 * write ports, each carried as one packed struct.
 */

`default_nettype none

package ex_pipe_pkg;

  import ex_isa_pkg::*;

  ////////////////////////////////////////////////////////////
  // Unit requests
  ////////////////////////////////////////////////////////////

  // ALU request, operand c is the jump target
  typedef struct packed {
    alu_op_e           op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] c;
  } alu_req_t;

  // Multiplier request
  typedef struct packed {
    mult_op_e          op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } mult_req_t;

  ////////////////////////////////////////////////////////////
  // Register file side
  ////////////////////////////////////////////////////////////

  // Destination of an instruction
  typedef struct packed {
    logic                 we;
    logic [RF_ADDR_W-1:0] addr;
  } rf_dest_t;

  // One register file write port
  typedef struct packed {
    logic                 we;
    logic [RF_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]    data;
  } rf_write_t;

endpackage

`default_nettype wire

/* hdl/ex_isa_pkg.sv */
/*
 * Instruction-level definitions for the execute stage.
 * Datapath widths and the ALU and multiplier opcode encodings,
 * shared by the request structs and by every functional unit.
 */

`default_nettype none

package ex_isa_pkg;

  // Datapath width, one machine word
  parameter int DATA_W = 32;

  // Register file address width, 64 entries
  parameter int RF_ADDR_W = 6;

  ////////////////////////////////////////////////////////////
  // ALU opcodes
  ////////////////////////////////////////////////////////////

  // Comparison opcodes return the flag in bit 0 of the result
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // Multiplier opcodes
  ////////////////////////////////////////////////////////////

  // Low word is single cycle, high words run multi-step
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_H   = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HU  = 2'd3
  } mult_op_e;

endpackage

`default_nettype wire
